// ==== common/hwpe_mem_pkg.sv ====
// ------------------------------------------------------------
// word memory port types, byte addressed, word aligned.
// no grant: a request with req high is taken that cycle.
// ------------------------------------------------------------
package hwpe_mem_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned WORD_BYTES = 4;  // word stride in bytes.

  typedef logic [ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [DATA_WIDTH-1:0] mem_data_t;

  typedef struct packed {
    logic      req;    // request strobe.
    logic      we;     // 1 = write, 0 = read.
    mem_addr_t addr;
    mem_data_t wdata;  // ignored on reads.
  } mem_req_t;

endpackage

// ==== common/hwpe_stream_pkg.sv ====
// ------------------------------------------------------------
// stream descriptor and flag types for the copy engine.
// strides are signed byte offsets, lengths count words/lines.
// line_length and feat_length must be nonzero.
// ------------------------------------------------------------
package hwpe_stream_pkg;

  // three-level walk: word, line, feature.
  typedef struct packed {
    logic        [31:0] base_addr;    // byte address of word 0.
    logic        [31:0] trans_size;   // total words in the stream.
    logic signed [15:0] line_stride;  // byte step between lines.
    logic        [15:0] line_length;  // words per line.
    logic signed [15:0] feat_stride;  // byte step between features.
    logic        [15:0] feat_length;  // lines per feature.
  } stream_config_t;

  // update flags follow the increment in the same cycle.
  typedef struct packed {
    logic word_update;  // a word was consumed.
    logic line_update;  // last word of a line.
    logic feat_update;  // last word of a feature.
    logic in_progress;  // stream still has words left.
  } stream_flags_t;

endpackage

// ==== hwpe_copy_top.f ====
common/hwpe_stream_pkg.sv
common/hwpe_mem_pkg.sv
streamer/hwpe_addressgen.sv
streamer/hwpe_source.sv
streamer/hwpe_sink.sv
source/hwpe_copy_ctrl.sv
source/hwpe_copy_top.sv
tb/tb_mem_model.sv
tb/tb_hwpe_copy.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the copy engine testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f hwpe_copy_top.f --top-module tb_hwpe_copy -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi

// ==== source/hwpe_copy_ctrl.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------
// copy sequencer: idle, run, drain.
// source and sink trans_size must match, else drain hangs.
// start_i is only taken in idle. done_o is a one-cycle pulse.
// ------------------------------------------------------------
module hwpe_copy_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start_i,
  input  hwpe_stream_pkg::stream_config_t src_cfg_i,
  input  hwpe_stream_pkg::stream_config_t dst_cfg_i,
  output hwpe_stream_pkg::stream_config_t src_cfg_o,
  output hwpe_stream_pkg::stream_config_t dst_cfg_o,
  input  logic                           sink_busy_i,
  input  logic                           rd_valid_i,
  output logic                           src_en_o,
  output logic                           dst_en_o,
  output logic                           sink_valid_o,
  output logic                           busy_o,
  output logic                           done_o
);
  import hwpe_stream_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN
  } state_e;

  state_e         state_q;
  state_e         state_d;
  stream_config_t src_cfg_q;
  stream_config_t dst_cfg_q;
  logic           launch;

  assign launch = (state_q == ST_IDLE) && start_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (start_i) state_d = ST_RUN;
      ST_RUN:   if (!rd_valid_i) state_d = ST_DRAIN;  // last read already issued.
      ST_DRAIN: if (!sink_busy_i) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      src_cfg_q    <= '0;
      dst_cfg_q    <= '0;
      sink_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      sink_valid_o <= rd_valid_i;  // one-cycle read latency.
      if (launch) begin
        src_cfg_q <= src_cfg_i;
        dst_cfg_q <= dst_cfg_i;
      end
    end
  end

  // streamers load their config on the start edge itself,
  // so the first read goes out in the first enabled cycle.
  assign src_cfg_o = launch ? src_cfg_i : src_cfg_q;
  assign dst_cfg_o = launch ? dst_cfg_i : dst_cfg_q;

  assign src_en_o = (state_q == ST_RUN);
  assign dst_en_o = (state_q == ST_RUN) || (state_q == ST_DRAIN);
  assign done_o   = (state_q == ST_DRAIN) && !sink_busy_i;
  assign busy_o   = (state_q != ST_IDLE) && !done_o;

endmodule

// ==== source/hwpe_copy_top.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------
// strided copy engine top level.
// both memory ports take a request every cycle, read data
// returns one cycle after the read. no back-pressure.
// ------------------------------------------------------------
module hwpe_copy_top #(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start_i,
  input  hwpe_stream_pkg::stream_config_t src_cfg_i,
  input  hwpe_stream_pkg::stream_config_t dst_cfg_i,
  input  hwpe_mem_pkg::mem_data_t        rd_rdata_i,
  output hwpe_mem_pkg::mem_req_t         rd_req_o,
  output hwpe_mem_pkg::mem_req_t         wr_req_o,
  output logic                           busy_o,
  output logic                           done_o,
  output logic                           feat_done_o
);
  import hwpe_stream_pkg::*;

  stream_config_t src_cfg_q;
  stream_config_t dst_cfg_q;
  logic           src_en;
  logic           dst_en;
  logic           rd_valid;
  logic           rd_valid_d;
  logic           sink_busy;

  hwpe_copy_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .src_cfg_i    (src_cfg_i),
    .dst_cfg_i    (dst_cfg_i),
    .src_cfg_o    (src_cfg_q),
    .dst_cfg_o    (dst_cfg_q),
    .sink_busy_i  (sink_busy),
    .rd_valid_i   (rd_valid),
    .src_en_o     (src_en),
    .dst_en_o     (dst_en),
    .sink_valid_o (rd_valid_d),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  hwpe_source #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_source (
    .clk        (clk),
    .rst_n      (rst_n),
    .en_i       (src_en),
    .cfg_i      (src_cfg_q),
    .rd_req_o   (rd_req_o),
    .rd_valid_o (rd_valid)
  );

  hwpe_sink #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_sink (
    .clk           (clk),
    .rst_n         (rst_n),
    .en_i          (dst_en),
    .cfg_i         (dst_cfg_q),
    .valid_i       (rd_valid_d),
    .rdata_i       (rd_rdata_i),
    .wr_req_o      (wr_req_o),
    .in_progress_o (sink_busy),
    .feat_done_o   (feat_done_o)
  );

endmodule

// ==== streamer/hwpe_addressgen.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------
// three-level strided address generator.
// config is loaded while en_i is low and held while enabled.
// largest trans_size is 2**CNT_WIDTH-1; zero gives no words.
// addr_o is combinational from the counters.
// ------------------------------------------------------------
module hwpe_addressgen #(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           en_i,
  input  logic                           inc_i,
  input  hwpe_stream_pkg::stream_config_t cfg_i,
  output hwpe_mem_pkg::mem_addr_t        addr_o,
  output hwpe_stream_pkg::stream_flags_t flags_o
);
  import hwpe_mem_pkg::*;

  mem_addr_t            base_addr_q;
  logic [CNT_WIDTH-1:0] trans_m1_q;
  logic [15:0]          line_len_m1_q;
  logic [15:0]          feat_len_m1_q;
  logic signed [15:0]   line_stride_q;
  logic signed [15:0]   feat_stride_q;

  logic [15:0]          word_cnt_q;
  logic [15:0]          line_cnt_q;
  logic [CNT_WIDTH-1:0] total_cnt_q;
  mem_addr_t            word_off_q;
  mem_addr_t            line_off_q;
  mem_addr_t            feat_off_q;
  logic                 in_progress_q;

  logic                 line_wrap;
  logic                 feat_wrap;
  mem_addr_t            line_step;
  mem_addr_t            feat_step;

  assign line_wrap = (word_cnt_q >= line_len_m1_q);  // last word of the line.
  assign feat_wrap = line_wrap && (line_cnt_q >= feat_len_m1_q);
  assign line_step = {{(ADDR_WIDTH-16){line_stride_q[15]}}, line_stride_q};
  assign feat_step = {{(ADDR_WIDTH-16){feat_stride_q[15]}}, feat_stride_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      base_addr_q   <= '0;
      trans_m1_q    <= '0;
      line_len_m1_q <= '0;
      feat_len_m1_q <= '0;
      line_stride_q <= '0;
      feat_stride_q <= '0;
    end else if (!en_i) begin
      base_addr_q   <= cfg_i.base_addr;
      trans_m1_q    <= cfg_i.trans_size[CNT_WIDTH-1:0] - 1'b1;
      line_len_m1_q <= cfg_i.line_length - 16'd1;
      feat_len_m1_q <= cfg_i.feat_length - 16'd1;
      line_stride_q <= cfg_i.line_stride;
      feat_stride_q <= cfg_i.feat_stride;
    end
  end

  // wrap order: word first, then line, then feature.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt_q    <= '0;
      line_cnt_q    <= '0;
      total_cnt_q   <= '0;
      word_off_q    <= '0;
      line_off_q    <= '0;
      feat_off_q    <= '0;
      in_progress_q <= 1'b0;
    end else if (!en_i) begin
      word_cnt_q    <= '0;
      line_cnt_q    <= '0;
      total_cnt_q   <= '0;
      word_off_q    <= '0;
      line_off_q    <= '0;
      feat_off_q    <= '0;
      in_progress_q <= (cfg_i.trans_size[CNT_WIDTH-1:0] != '0);  // armed for next enable.
    end else if (inc_i) begin
      total_cnt_q <= total_cnt_q + 1'b1;
      if (total_cnt_q == trans_m1_q) begin
        in_progress_q <= 1'b0;  // last word consumed.
      end
      if (!line_wrap) begin
        word_cnt_q <= word_cnt_q + 16'd1;
        word_off_q <= word_off_q + mem_addr_t'(WORD_BYTES);
      end else if (!feat_wrap) begin
        word_cnt_q <= '0;
        word_off_q <= '0;
        line_cnt_q <= line_cnt_q + 16'd1;
        line_off_q <= line_off_q + line_step;
      end else begin
        word_cnt_q <= '0;
        word_off_q <= '0;
        line_cnt_q <= '0;
        line_off_q <= '0;
        feat_off_q <= feat_off_q + feat_step;
      end
    end
  end

  assign addr_o = base_addr_q + feat_off_q + line_off_q + word_off_q;

  assign flags_o.word_update = inc_i;
  assign flags_o.line_update = inc_i && line_wrap;
  assign flags_o.feat_update = inc_i && feat_wrap;
  assign flags_o.in_progress = en_i && in_progress_q;  // low outside the enabled window.

endmodule

// ==== streamer/hwpe_sink.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------
// sink streamer: writes each valid word at the next sink
// address in the same cycle. valid_i must already be aligned
// to the read data. words past trans_size are dropped.
// ------------------------------------------------------------
module hwpe_sink #(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           en_i,
  input  hwpe_stream_pkg::stream_config_t cfg_i,
  input  logic                           valid_i,
  input  hwpe_mem_pkg::mem_data_t        rdata_i,
  output hwpe_mem_pkg::mem_req_t         wr_req_o,
  output logic                           in_progress_o,
  output logic                           feat_done_o
);
  import hwpe_stream_pkg::*;
  import hwpe_mem_pkg::*;

  stream_flags_t flags;
  mem_addr_t     wr_addr;
  logic          write;

  assign write = valid_i && flags.in_progress;

  hwpe_addressgen #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_addrgen (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (en_i),
    .inc_i   (write),
    .cfg_i   (cfg_i),
    .addr_o  (wr_addr),
    .flags_o (flags)
  );

  always_comb begin
    wr_req_o.req   = write;
    wr_req_o.we    = 1'b1;
    wr_req_o.addr  = wr_addr;
    wr_req_o.wdata = rdata_i;  // straight copy, no transform.
  end

  // pulses with the write that closes a feature.
  assign feat_done_o   = flags.feat_update;
  assign in_progress_o = flags.in_progress;

endmodule

// ==== streamer/hwpe_source.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------
// source streamer: one read per cycle while in progress.
// the read port must accept every request, data comes back
// one cycle later and is aligned by the controller.
// ------------------------------------------------------------
module hwpe_source #(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           en_i,
  input  hwpe_stream_pkg::stream_config_t cfg_i,
  output hwpe_mem_pkg::mem_req_t         rd_req_o,
  output logic                           rd_valid_o
);
  import hwpe_stream_pkg::*;
  import hwpe_mem_pkg::*;

  stream_flags_t flags;
  mem_addr_t     rd_addr;
  logic          issue;

  // in_progress already carries en_i.
  assign issue = flags.in_progress;

  hwpe_addressgen #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_addrgen (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (en_i),
    .inc_i   (issue),
    .cfg_i   (cfg_i),
    .addr_o  (rd_addr),
    .flags_o (flags)
  );

  always_comb begin
    rd_req_o.req   = issue;
    rd_req_o.we    = 1'b0;     // read only.
    rd_req_o.addr  = rd_addr;
    rd_req_o.wdata = '0;
  end

  assign rd_valid_o = issue;  // high in the issue cycle.

endmodule

// ==== tb/tb_hwpe_copy.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------
// copy engine testbench, table of cases run in order.
// memory is 1024 words, all streams must stay inside it.
// source and destination regions must not overlap.
// ------------------------------------------------------------
module tb_hwpe_copy;
  import hwpe_stream_pkg::*;
  import hwpe_mem_pkg::*;

  localparam int unsigned DEPTH   = 1024;
  localparam int unsigned N_CASES = 4;

  typedef struct packed {
    stream_config_t src;
    stream_config_t dst;
    logic           b2b;  // extra start while busy.
  } case_t;

  logic           clk;
  logic           rst_n;
  logic           start_i;
  stream_config_t src_cfg_i;
  stream_config_t dst_cfg_i;
  mem_data_t      rd_rdata;
  mem_req_t       rd_req;
  mem_req_t       wr_req;
  logic           busy;
  logic           done;
  logic           feat_done;
  logic           load_en;
  logic [31:0]    load_idx;
  mem_data_t      load_data;

  case_t       cases [N_CASES];
  mem_data_t   exp_img [DEPTH];
  logic [31:0] rng;
  longint      wd_limit;
  logic        wd_armed;

  hwpe_copy_top #(.CNT_WIDTH(16)) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .src_cfg_i   (src_cfg_i),
    .dst_cfg_i   (dst_cfg_i),
    .rd_rdata_i  (rd_rdata),
    .rd_req_o    (rd_req),
    .wr_req_o    (wr_req),
    .busy_o      (busy),
    .done_o      (done),
    .feat_done_o (feat_done)
  );

  tb_mem_model #(.DEPTH(DEPTH)) u_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_req_i    (rd_req),
    .rd_rdata_o  (rd_rdata),
    .wr_req_i    (wr_req),
    .load_en_i   (load_en),
    .load_idx_i  (load_idx),
    .load_data_i (load_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic stream_config_t make_cfg(input logic [31:0] base, input int n,
                                              input int ls, input int ll,
                                              input int fs, input int fl);
    stream_config_t c;
    c.base_addr   = base;
    c.trans_size  = n;
    c.line_stride = 16'(ls);
    c.line_length = 16'(ll);
    c.feat_stride = 16'(fs);
    c.feat_length = 16'(fl);
    return c;
  endfunction

  // address of word n from the word/line/feature rule.
  function automatic logic [31:0] word_addr(input stream_config_t c, input int n);
    int w;
    int l;
    int f;
    w = n % int'(c.line_length);
    l = (n / int'(c.line_length)) % int'(c.feat_length);
    f = n / (int'(c.line_length) * int'(c.feat_length));
    return c.base_addr + 32'(f * int'(c.feat_stride)) + 32'(l * int'(c.line_stride))
           + 32'(w * int'(WORD_BYTES));
  endfunction

  task automatic fail_now();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input logic [31:0] addr, input mem_data_t exp_v,
                            input mem_data_t act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] mem[%h] expected %h got %h", addr, exp_v, act_v);
      fail_now();
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s expected %h got %h", name, exp_v, act_v);
      fail_now();
    end
  endtask

  task automatic check_count(input string name, input int exp_v, input int act_v);
    if (act_v != exp_v) begin
      $display("[FAIL] %s expected %h got %h", name, exp_v, act_v);
      fail_now();
    end
  endtask

  task automatic model_copy(input case_t tc);
    mem_data_t   vals [$];
    logic [31:0] a;
    for (int n = 0; n < int'(tc.src.trans_size); n++) begin
      a = word_addr(tc.src, n);
      if (a >= DEPTH * WORD_BYTES) begin
        $display("source address %h lies outside the memory model", a);
        fail_now();
      end
      vals.push_back(exp_img[a[11:2]]);
    end
    for (int n = 0; n < int'(tc.dst.trans_size); n++) begin
      a = word_addr(tc.dst, n);
      if (a >= DEPTH * WORD_BYTES) begin
        $display("destination address %h lies outside the memory model", a);
        fail_now();
      end
      exp_img[a[11:2]] = vals[n];
    end
  endtask

  task automatic run_case(input case_t tc);
    int n;
    int feats;
    n = int'(tc.src.trans_size);
    feats = 0;
    @(posedge clk);
    #1;
    src_cfg_i = tc.src;
    dst_cfg_i = tc.dst;
    start_i   = 1'b1;
    @(posedge clk);  // start sampled here.
    #1;
    start_i = 1'b0;
    for (int c = 1; c <= n + 3; c++) begin
      check_flag("busy_o", (c <= n + 1), busy);
      check_flag("done_o", (c == n + 2), done);
      if (feat_done) feats++;
      if (tc.b2b && c == 2) begin
        src_cfg_i = make_cfg(32'h000, n, 0, n, 0, 1);  // would clobber if taken.
        dst_cfg_i = make_cfg(32'h600, n, 0, n, 0, 1);
        start_i   = 1'b1;
      end else begin
        start_i = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    check_count("feat_done_o count",
                n / (int'(tc.dst.line_length) * int'(tc.dst.feat_length)), feats);
    model_copy(tc);
    for (int i = 0; i < DEPTH; i++) begin
      check_word(32'(i * 4), exp_img[i], u_mem.mem[i]);
    end
  endtask

  initial begin
    wait (wd_armed);
    #(wd_limit);
    $display("watchdog expired, the copy engine never finished");
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    longint cycles;
    wd_armed  = 1'b0;
    rst_n     = 1'b0;
    start_i   = 1'b0;
    src_cfg_i = '0;
    dst_cfg_i = '0;
    load_en   = 1'b0;
    load_idx  = '0;
    load_data = '0;

    cases[0] = '{make_cfg(32'h000, 32, 0, 32, 0, 1),
                 make_cfg(32'h800, 32, 0, 32, 0, 1), 1'b0};  // contiguous.
    cases[1] = '{make_cfg(32'h100, 24, 32, 6, 128, 4),
                 make_cfg(32'h980, 24, -16, 4, 0, 6), 1'b0};
    cases[2] = '{make_cfg(32'h200, 36, 16, 3, 64, 4),
                 make_cfg(32'hB00, 36, 8, 2, -64, 3), 1'b1};
    cases[3] = '{make_cfg(32'h300, 20, 20, 5, 48, 2),
                 make_cfg(32'hD00, 20, 12, 3, 40, 2), 1'b1};  // partial feature.

    cycles = DEPTH + 32;
    foreach (cases[i]) cycles += longint'(cases[i].src.trans_size) + 20;
    wd_limit = cycles * 4;
    wd_armed = 1'b1;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_flag("busy_o", 1'b0, busy);
    check_flag("done_o", 1'b0, done);
    check_flag("feat_done_o", 1'b0, feat_done);
    check_flag("rd_req_o.req", 1'b0, rd_req.req);
    check_flag("wr_req_o.req", 1'b0, wr_req.req);

    // prefill through the load port while the engine is idle.
    rng = 32'd81902;
    for (int i = 0; i < DEPTH; i++) begin
      rng        = next_rand(rng);
      exp_img[i] = rng;
      load_en    = 1'b1;
      load_idx   = i;
      load_data  = rng;
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;

    foreach (cases[i]) run_case(cases[i]);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== tb/tb_mem_model.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------
// word memory for the testbench, DEPTH words from address 0.
// read data returns one cycle after the request.
// load port has priority over the write port.
// ------------------------------------------------------------
module tb_mem_model #(
  parameter int unsigned DEPTH = 1024
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  hwpe_mem_pkg::mem_req_t  rd_req_i,
  output hwpe_mem_pkg::mem_data_t rd_rdata_o,
  input  hwpe_mem_pkg::mem_req_t  wr_req_i,
  input  logic                    load_en_i,
  input  logic [31:0]             load_idx_i,
  input  hwpe_mem_pkg::mem_data_t load_data_i
);
  import hwpe_mem_pkg::*;

  localparam int unsigned IDX_W = $clog2(DEPTH);

  mem_data_t mem [DEPTH];

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  assign rd_idx = rd_req_i.addr[IDX_W+1:2];  // word index.
  assign wr_idx = wr_req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_rdata_o <= '0;
    end else if (rd_req_i.req && !rd_req_i.we) begin
      rd_rdata_o <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (load_en_i) begin
      mem[load_idx_i[IDX_W-1:0]] <= load_data_i;
    end else if (wr_req_i.req && wr_req_i.we) begin
      mem[wr_idx] <= wr_req_i.wdata;
    end
  end

endmodule
